// File: Makefile
# Verilator build and run for the OLED driver testbench

VERILATOR  ?= verilator
TOP        ?= oled_tb
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --assert --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: design/oled_ctrl.sv
`default_nettype none

// Phase controller and serializer source mux
module oled_ctrl #(
    parameter int RESET_CYCLES = 1000
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            init_req,
    input  wire oled_pkg::byte_t init_byte,
    input  wire logic            init_dc,
    input  wire logic            init_finished,
    input  wire logic            draw_req,
    input  wire oled_pkg::byte_t draw_byte,
    input  wire logic            draw_dc,
    input  wire logic            draw_finished,
    input  wire logic            tx_done,
    output logic                 res,
    output logic                 init_start,
    output logic                 draw_start,
    output logic                 init_byte_done,
    output logic                 draw_byte_done,
    output logic                 tx_send,
    output oled_pkg::byte_t      tx_byte,
    output logic                 tx_dc
);

    localparam int TMR_W = $clog2(RESET_CYCLES + 1);

    oled_pkg::phase_t phase_r;
    logic [TMR_W-1:0] tmr_r;

    ////////////////////////////////////////
    // Phase sequencing
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_r    <= oled_pkg::PH_RESET;
            tmr_r      <= '0;
            res        <= 1'b0;
            init_start <= 1'b0;
            draw_start <= 1'b0;
        end else begin
            init_start <= 1'b0;
            draw_start <= 1'b0;
            case (phase_r)
                oled_pkg::PH_RESET: begin
                    if (!res) begin
                        // Panel reset pulse
                        if (tmr_r == TMR_W'(RESET_CYCLES - 1)) begin
                            res <= 1'b1;
                        end else begin
                            tmr_r <= tmr_r + 1'b1;
                        end
                    end else begin
                        phase_r    <= oled_pkg::PH_INIT;
                        init_start <= 1'b1;
                    end
                end
                oled_pkg::PH_INIT: begin
                    if (init_finished) begin
                        phase_r    <= oled_pkg::PH_DRAW;
                        draw_start <= 1'b1;
                    end
                end
                oled_pkg::PH_DRAW: begin
                    // Redraw forever
                    if (draw_finished) begin
                        draw_start <= 1'b1;
                    end
                end
                default: phase_r <= oled_pkg::PH_RESET;
            endcase
        end
    end

    ////////////////////////////////////////
    // Serializer source
    ////////////////////////////////////////
    always_comb begin
        tx_send = 1'b0;
        tx_byte = '0;
        tx_dc   = 1'b0;
        case (phase_r)
            oled_pkg::PH_INIT: begin
                tx_send = init_req;
                tx_byte = init_byte;
                tx_dc   = init_dc;
            end
            oled_pkg::PH_DRAW: begin
                tx_send = draw_req;
                tx_byte = draw_byte;
                tx_dc   = draw_dc;
            end
            default: begin
            end
        endcase
    end

    // Completion goes back to the active source only
    assign init_byte_done = tx_done && (phase_r == oled_pkg::PH_INIT);
    assign draw_byte_done = tx_done && (phase_r == oled_pkg::PH_DRAW);

    // Idle sequencer stays quiet
    a_inactive_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !((phase_r != oled_pkg::PH_INIT && init_req) ||
          (phase_r != oled_pkg::PH_DRAW && draw_req)))
        else $error("request from inactive source");

endmodule

`default_nettype wire

// File: design/oled_frame_draw.sv
`default_nettype none

// Frame painter, page header then column data
module oled_frame_draw #(
    parameter int PAGES   = 8,
    parameter int COLUMNS = 128
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       start,
    input  wire logic [1:0] pattern,
    input  wire logic       byte_done,
    output logic            req,
    output oled_pkg::byte_t byte_out,
    output logic            dc_out,
    output logic            finished
);

    localparam int PG_W  = (PAGES > 1) ? $clog2(PAGES) : 1;
    localparam int COL_W = (COLUMNS > 1) ? $clog2(COLUMNS) : 1;

    // Byte kind within a page
    localparam logic [1:0] S_PAGE   = 2'd0;
    localparam logic [1:0] S_COL_LO = 2'd1;
    localparam logic [1:0] S_COL_HI = 2'd2;
    localparam logic [1:0] S_DATA   = 2'd3;

    logic [PG_W-1:0]  page_r;
    logic [COL_W-1:0] col_r;
    logic [1:0]       step_r;
    logic [1:0]       pat_r;
    logic             active_r;
    oled_pkg::byte_t  pat_byte;

    ////////////////////////////////////////
    // Byte generation
    ////////////////////////////////////////
    always_comb begin
        pat_byte = 8'h00;
        case (pat_r)
            oled_pkg::PAT_FILL:    pat_byte = 8'hFF;
            oled_pkg::PAT_CLEAR:   pat_byte = 8'h00;
            // Odd columns get the shifted stripe
            oled_pkg::PAT_CHECKER: pat_byte = col_r[0] ? 8'h55 : 8'hAA;
            oled_pkg::PAT_RAMP:    pat_byte = oled_pkg::byte_t'(col_r);
        endcase
    end

    always_comb begin
        case (step_r)
            S_PAGE:   byte_out = oled_pkg::PAGE_CMD_BASE + oled_pkg::byte_t'(page_r);
            S_COL_LO: byte_out = oled_pkg::COL_LO_CMD;
            S_COL_HI: byte_out = oled_pkg::COL_HI_CMD;
            default:  byte_out = pat_byte;
        endcase
    end

    // Data bytes only in the column part
    assign dc_out = (step_r == S_DATA);

    ////////////////////////////////////////
    // Page and column walk
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            page_r   <= '0;
            col_r    <= '0;
            step_r   <= S_PAGE;
            pat_r    <= oled_pkg::PAT_FILL;
            active_r <= 1'b0;
            req      <= 1'b0;
            finished <= 1'b0;
        end else begin
            req      <= 1'b0;
            finished <= 1'b0;
            if (start) begin
                // One pattern per frame
                pat_r    <= pattern;
                page_r   <= '0;
                col_r    <= '0;
                step_r   <= S_PAGE;
                active_r <= 1'b1;
                req      <= 1'b1;
            end else if (active_r && byte_done) begin
                if (step_r != S_DATA) begin
                    step_r <= step_r + 2'd1;
                    req    <= 1'b1;
                end else if (col_r == COL_W'(COLUMNS - 1)) begin
                    col_r  <= '0;
                    step_r <= S_PAGE;
                    if (page_r == PG_W'(PAGES - 1)) begin
                        // Frame done
                        active_r <= 1'b0;
                        finished <= 1'b1;
                    end else begin
                        page_r <= page_r + 1'b1;
                        req    <= 1'b1;
                    end
                end else begin
                    col_r <= col_r + 1'b1;
                    req   <= 1'b1;
                end
            end
        end
    end

    // Data part opens at column 0, right after the column-high command
    a_data_part: assert property (@(posedge clk) disable iff (!rst_n)
        (req && $rose(dc_out)) |-> (col_r == '0 && $past(step_r) == S_COL_HI))
        else $error("data byte outside the column part of a page");

endmodule

`default_nettype wire

// File: design/oled_init_seq.sv
`default_nettype none

// Power-up command player
module oled_init_seq (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  start,
    input  wire logic  byte_done,
    output logic            req,
    output oled_pkg::byte_t byte_out,
    output logic            dc_out,
    output logic            finished
);

    localparam int IDX_W = $clog2(oled_pkg::INIT_LEN);

    logic [IDX_W-1:0] idx_r;
    logic             active_r;
    logic             last_idx;

    assign last_idx = (idx_r == IDX_W'(oled_pkg::INIT_LEN - 1));

    // Table entry for the current step
    assign byte_out = oled_pkg::INIT_CMDS[idx_r];
    // Init bytes are all commands
    assign dc_out   = 1'b0;

    ////////////////////////////////////////
    // Step through the table
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_r    <= '0;
            active_r <= 1'b0;
            req      <= 1'b0;
            finished <= 1'b0;
        end else begin
            // Strobes last one cycle
            req      <= 1'b0;
            finished <= 1'b0;
            if (start) begin
                idx_r    <= '0;
                active_r <= 1'b1;
                req      <= 1'b1;
            end else if (active_r && byte_done) begin
                if (last_idx) begin
                    // Last command sent
                    active_r <= 1'b0;
                    finished <= 1'b1;
                end else begin
                    idx_r <= idx_r + 1'b1;
                    req   <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Completions only for our own requests, index stays in the table
    a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        byte_done |-> (active_r && (idx_r < IDX_W'(oled_pkg::INIT_LEN))))
        else $error("init index past table or stray byte_done");

endmodule

`default_nettype wire

// File: design/oled_pkg.sv
`default_nettype none

package oled_pkg;

    // One SPI byte, command or pixel data
    typedef logic [7:0] byte_t;

    // Controller phases
    typedef enum logic [1:0] {
        PH_RESET = 2'd0,
        PH_INIT  = 2'd1,
        PH_DRAW  = 2'd2
    } phase_t;

    ////////////////////////////////////////
    // Fill patterns
    ////////////////////////////////////////
    localparam logic [1:0] PAT_FILL    = 2'd0;
    localparam logic [1:0] PAT_CLEAR   = 2'd1;
    localparam logic [1:0] PAT_CHECKER = 2'd2;
    localparam logic [1:0] PAT_RAMP    = 2'd3;

    ////////////////////////////////////////
    // Power-up command table
    ////////////////////////////////////////
    localparam int INIT_LEN = 25;

    localparam byte_t INIT_CMDS [INIT_LEN] = '{
        8'hAE,          // display off
        8'hD5, 8'h80,   // clock divide
        8'hA8, 8'h3F,   // multiplex 64
        8'hD3, 8'h00,   // no offset
        8'h40,          // start line 0
        8'h8D, 8'h14,   // charge pump on
        8'h20, 8'h00,   // horizontal addressing
        8'hA1,          // segment remap
        8'hC8,          // COM scan reversed
        8'hDA, 8'h12,   // COM pins
        8'h81, 8'hCF,   // contrast
        8'hD9, 8'hF1,   // precharge
        8'hDB, 8'h40,   // VCOMH level
        8'hA4,          // follow RAM, entire-display off
        8'hA6,          // normal, not inverted
        8'hAF           // display on
    };

    // Page and column address opcodes
    localparam byte_t PAGE_CMD_BASE = 8'hB0;
    localparam byte_t COL_LO_CMD    = 8'h00;
    localparam byte_t COL_HI_CMD    = 8'h10;

endpackage

`default_nettype wire

// File: design/oled_spi_tx.sv
`default_nettype none

// SPI mode 0 byte serializer, MSB first
module oled_spi_tx #(
    parameter int CLK_DIV = 4
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            send,
    input  wire oled_pkg::byte_t byte_in,
    input  wire logic            dc_in,
    output logic                 busy,
    output logic                 done,
    output logic                 sck,
    output logic                 mosi,
    output logic                 cs,
    output logic                 dc
);

    // Half-period counter needs at least one bit
    localparam int HALF_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [HALF_W-1:0] half_cnt;
    logic [2:0]        bit_cnt;
    oled_pkg::byte_t   shift_r;
    logic              half_end;

    // End of the current sck half period
    assign half_end  = (half_cnt == HALF_W'(CLK_DIV - 1));

    // cs low marks a byte in flight
    assign busy = ~cs;
    assign mosi = shift_r[7];

    ////////////////////////////////////////
    // Serializer
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half_cnt <= '0;
            bit_cnt  <= '0;
            shift_r  <= '0;
            sck      <= 1'b0;
            cs       <= 1'b1;
            dc       <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (cs) begin
                // Idle, wait for a byte
                if (send) begin
                    cs       <= 1'b0;
                    dc       <= dc_in;
                    shift_r  <= byte_in;
                    half_cnt <= '0;
                    bit_cnt  <= '0;
                end
            end else if (half_end) begin
                half_cnt <= '0;
                if (!sck) begin
                    // Rising edge, panel samples here
                    sck <= 1'b1;
                end else begin
                    sck <= 1'b0;
                    if (bit_cnt == 3'd7) begin
                        // Byte complete
                        cs   <= 1'b1;
                        done <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 3'd1;
                        // Next bit on the falling edge
                        shift_r <= {shift_r[6:0], 1'b0};
                    end
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Controller must wait for the previous byte
    a_send_idle: assert property (@(posedge clk) disable iff (!rst_n)
        send |-> !busy)
        else $error("send while serializer busy");

    // cs low for exactly eight bit times, sixteen half periods
    a_cs_frame: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cs) |-> ($past(cs, 16 * CLK_DIV + 1) && !$past(cs, 16 * CLK_DIV)))
        else $error("cs rose before the byte completed");

endmodule

`default_nettype wire

// File: design/oled_top.sv
`default_nettype none

// OLED panel driver top
module oled_top #(
    parameter int CLK_DIV      = 4,
    parameter int RESET_CYCLES = 1000,
    parameter int PAGES        = 8,
    parameter int COLUMNS      = 128
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic [1:0] pattern,
    output logic            sck,
    output logic            mosi,
    output logic            cs,
    output logic            dc,
    output logic            res
);

    // Serializer side
    logic            tx_send;
    oled_pkg::byte_t tx_byte;
    logic            tx_dc;
    logic            tx_busy;
    logic            tx_done;

    // Init sequencer side
    logic            init_start;
    logic            init_req;
    oled_pkg::byte_t init_byte;
    logic            init_dc;
    logic            init_byte_done;
    logic            init_finished;

    // Frame painter side
    logic            draw_start;
    logic            draw_req;
    oled_pkg::byte_t draw_byte;
    logic            draw_dc;
    logic            draw_byte_done;
    logic            draw_finished;

    ////////////////////////////////////////
    // Controller
    ////////////////////////////////////////
    oled_ctrl #(
        .RESET_CYCLES (RESET_CYCLES)
    ) u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .init_req       (init_req),
        .init_byte      (init_byte),
        .init_dc        (init_dc),
        .init_finished  (init_finished),
        .draw_req       (draw_req),
        .draw_byte      (draw_byte),
        .draw_dc        (draw_dc),
        .draw_finished  (draw_finished),
        .tx_done        (tx_done),
        .res            (res),
        .init_start     (init_start),
        .draw_start     (draw_start),
        .init_byte_done (init_byte_done),
        .draw_byte_done (draw_byte_done),
        .tx_send        (tx_send),
        .tx_byte        (tx_byte),
        .tx_dc          (tx_dc)
    );

    ////////////////////////////////////////
    // Datapath blocks
    ////////////////////////////////////////
    oled_spi_tx #(
        .CLK_DIV (CLK_DIV)
    ) u_spi_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .send    (tx_send),
        .byte_in (tx_byte),
        .dc_in   (tx_dc),
        .busy    (tx_busy),
        .done    (tx_done),
        .sck     (sck),
        .mosi    (mosi),
        .cs      (cs),
        .dc      (dc)
    );

    oled_init_seq u_init_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (init_start),
        .byte_done (init_byte_done),
        .req       (init_req),
        .byte_out  (init_byte),
        .dc_out    (init_dc),
        .finished  (init_finished)
    );

    oled_frame_draw #(
        .PAGES   (PAGES),
        .COLUMNS (COLUMNS)
    ) u_frame_draw (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (draw_start),
        .pattern   (pattern),
        .byte_done (draw_byte_done),
        .req       (draw_req),
        .byte_out  (draw_byte),
        .dc_out    (draw_dc),
        .finished  (draw_finished)
    );

    // Sequencers only ask once the serializer is free again
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        (init_req || draw_req) |-> !tx_busy)
        else $error("byte request while serializer busy");

endmodule

`default_nettype wire

// File: project.f
design/oled_pkg.sv
design/oled_spi_tx.sv
design/oled_init_seq.sv
design/oled_frame_draw.sv
design/oled_ctrl.sv
design/oled_top.sv
test/oled_tb.sv

// File: test/oled_tb.sv
`default_nettype none

module oled_tb;

    // Small panel so a run stays short
    localparam int CLK_DIV      = 2;
    localparam int RESET_CYCLES = 20;
    localparam int PAGES        = 2;
    localparam int COLUMNS      = 8;

    localparam int PAGE_LEN    = 3 + COLUMNS;
    localparam int FRAME_LEN   = PAGES * PAGE_LEN;
    localparam int BYTE_CYCLES = 16 * CLK_DIV + 4;
    // Two inits, two full frames, one cut frame, one frame after restart
    localparam int RUN_BYTES   = 2 * oled_pkg::INIT_LEN + 4 * FRAME_LEN;
    localparam int TIMEOUT_CYCLES = RUN_BYTES * BYTE_CYCLES
                                  + 2 * (RESET_CYCLES + 5) + 10 * BYTE_CYCLES;

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    logic [1:0] pattern = oled_pkg::PAT_FILL;
    wire        sck;
    wire        mosi;
    wire        cs;
    wire        dc;
    wire        res;

    int              seed = 47;
    int              errors = 0;
    int              cycle_cnt = 0;
    int              byte_total = 0;
    // Decoder and stream state
    int              rst_low_cnt = 0;
    int              rel_cnt = 0;
    int              edge_cnt = 0;
    int              stream_cnt = 0;
    int              frames_done = 0;
    int              frame_pos = 0;
    logic            sck_q = 1'b0;
    logic            cs_q = 1'b1;
    logic            dc_win = 1'b0;
    oled_pkg::byte_t shift_byte = '0;
    logic [1:0]      frame_pat = oled_pkg::PAT_FILL;
    logic [3:0]      pat_seen = '0;
    logic [3:0]      chosen = '0;

    oled_top #(
        .CLK_DIV      (CLK_DIV),
        .RESET_CYCLES (RESET_CYCLES),
        .PAGES        (PAGES),
        .COLUMNS      (COLUMNS)
    ) UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .pattern (pattern),
        .sck     (sck),
        .mosi    (mosi),
        .cs      (cs),
        .dc      (dc),
        .res     (res)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic oled_pkg::byte_t pattern_byte(input logic [1:0] pat, input int col);
        oled_pkg::byte_t b;
        case (pat)
            oled_pkg::PAT_FILL:    b = 8'hFF;
            oled_pkg::PAT_CLEAR:   b = 8'h00;
            oled_pkg::PAT_CHECKER: b = (col % 2 == 0) ? 8'hAA : 8'h55;
            default:               b = oled_pkg::byte_t'(col & 255);
        endcase
        return b;
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("CHECK FAILED t=%0t %s: expected %0h, got %0h", $time, name, expected, actual);
    endtask

    // Compare one decoded byte with its place in the stream
    task automatic check_byte(input oled_pkg::byte_t got, input logic got_dc);
        int              pos;
        int              page;
        int              off;
        oled_pkg::byte_t exp_b;
        logic            exp_dc;
        if (stream_cnt < oled_pkg::INIT_LEN) begin
            exp_b  = oled_pkg::INIT_CMDS[stream_cnt];
            exp_dc = 1'b0;
        end else begin
            pos = (stream_cnt - oled_pkg::INIT_LEN) % FRAME_LEN;
            // Pattern in force when the frame opens
            if (pos == 0) begin
                frame_pat = pattern;
            end
            page   = pos / PAGE_LEN;
            off    = pos % PAGE_LEN;
            exp_dc = (off >= 3);
            if (off == 0) begin
                exp_b = oled_pkg::PAGE_CMD_BASE + oled_pkg::byte_t'(page);
            end else if (off == 1) begin
                exp_b = oled_pkg::COL_LO_CMD;
            end else if (off == 2) begin
                exp_b = oled_pkg::COL_HI_CMD;
            end else begin
                exp_b = pattern_byte(frame_pat, off - 3);
                // Pattern counts as covered once the panel gets it right
                if (got == exp_b && got_dc) begin
                    pat_seen[frame_pat] = 1'b1;
                end
            end
            if (pos == FRAME_LEN - 1) begin
                frames_done++;
                frame_pos = 0;
            end else begin
                frame_pos = pos + 1;
            end
        end
        assert (got_dc == exp_dc) else report_mismatch("dc", int'(exp_dc), int'(got_dc));
        assert (got == exp_b) else report_mismatch("mosi byte", int'(exp_b), int'(got));
        stream_cnt++;
        byte_total++;
    endtask

    ////////////////////////////////////////
    // SPI decoder, sampled at posedge
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (!rst_n) begin
            // Skip the very first edge, DUT flops may not be reset yet
            if (rst_low_cnt > 0) begin
                assert (cs == 1'b1) else report_mismatch("cs", 1, int'(cs));
                assert (sck == 1'b0) else report_mismatch("sck", 0, int'(sck));
                assert (res == 1'b0) else report_mismatch("res", 0, int'(res));
            end
            rst_low_cnt++;
            rel_cnt     = 0;
            stream_cnt  = 0;
            frames_done = 0;
            frame_pos   = 0;
            edge_cnt    = 0;
            shift_byte  = '0;
            sck_q       = 1'b0;
            cs_q        = 1'b1;
        end else begin
            rst_low_cnt = 0;
            // Panel reset ends exactly RESET_CYCLES after release
            assert (res == (rel_cnt >= RESET_CYCLES))
                else report_mismatch("res", int'(rel_cnt >= RESET_CYCLES), int'(res));
            rel_cnt++;
            if (!cs) begin
                if (cs_q) begin
                    // Window opens
                    edge_cnt = 0;
                    dc_win   = dc;
                end else begin
                    assert (dc == dc_win) else report_mismatch("dc", int'(dc_win), int'(dc));
                end
                if (sck && !sck_q) begin
                    shift_byte = {shift_byte[6:0], mosi};
                    edge_cnt++;
                end
            end else if (!cs_q) begin
                assert (edge_cnt == 8) else report_mismatch("sck rising edges", 8, edge_cnt);
                check_byte(shift_byte, dc_win);
            end
            sck_q = sck;
            cs_q  = cs;
        end
    end

    // mosi moves on falling sck only
    mosi_on_low_sck: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(mosi) |-> !sck)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t sck: expected 0, got 1 at a mosi change", $time);
        end

    // Quiet bus until the panel is out of reset
    cs_idle_in_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !res |-> cs)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t cs: expected 1, got 0 while res low", $time);
        end

    sck_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
        cs |-> !sck)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t sck: expected 0, got 1 while cs high", $time);
        end

    ////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: byte stream stalled, %0d bytes after %0d cycles",
                     byte_total, cycle_cnt);
            $display("** FAIL **");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Stimulus, driven on negedge
    ////////////////////////////////////////
    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // Block until a frame has decoded at least pos bytes
    task automatic wait_frame_pos(input int frames, input int pos);
        while (!(frames_done > frames || (frames_done == frames && frame_pos >= pos))) begin
            @(negedge clk);
        end
    endtask

    // Random pick among patterns not used yet
    task automatic pick_new_pattern(output logic [1:0] p);
        logic [1:0] free [4];
        int         cnt;
        int         idx;
        cnt = 0;
        for (int k = 0; k < 4; k++) begin
            if (!chosen[k]) begin
                free[cnt] = 2'(k);
                cnt++;
            end
        end
        idx = {$random(seed)} % cnt;
        p = free[idx];
        chosen[p] = 1'b1;
    endtask

    initial begin
        int         change_pos;
        logic [1:0] next_pat;
        change_pos = 4;
        chosen[oled_pkg::PAT_FILL] = 1'b1;
        apply_reset();
        // Change lands mid-frame, well clear of both frame edges
        for (int f = 0; f < 3; f++) begin
            change_pos = 4 + ({$random(seed)} % (FRAME_LEN - 8));
            wait_frame_pos(f, change_pos);
            pick_new_pattern(next_pat);
            pattern = next_pat;
        end
        // Cut the third frame short
        wait_frame_pos(2, change_pos + 2);
        @(negedge clk);
        apply_reset();
        // Full init again, then one whole frame
        wait_frame_pos(1, 0);
        if (pat_seen != 4'hF) begin
            errors++;
            $display("Not every fill pattern reached the panel, seen mask %b", pat_seen);
        end
        $display("Summary: %0d errors, %0d bytes decoded, %0d cycles",
                 errors, byte_total, cycle_cnt);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
